// File: Bender.yml
package:
  name: epcore

sources:
  - files:
      - hw/epCorePkg.sv
      - hw/epDecoder.sv
      - hw/epRegFile.sv
      - hw/epExecUnit.sv
      - hw/epSequencer.sv
      - hw/epCore.sv
  - target: test
    files:
      - verif/epCore_chk.sv
      - verif/epCoreTb.sv

// File: epCore.f
hw/epCorePkg.sv
hw/epDecoder.sv
hw/epRegFile.sv
hw/epExecUnit.sv
hw/epSequencer.sv
hw/epCore.sv
verif/epCore_chk.sv
verif/epCoreTb.sv

// File: hw/epCore.sv
`timescale 1ns/1ps
`default_nettype none

module epCore #(
    parameter epCorePkg::wordT ResetVector = '0
) (
    input  logic            iClk,
    input  logic            rstN,
    input  epCorePkg::wordT memRdData,
    output epCorePkg::wordT memAddr,
    output epCorePkg::wordT memWrData,
    output logic            memWrite,
    output logic            halted
);

    // Decoder outputs
    logic              isBranch, isLoad, isStore, isDirect;
    logic              isAlu, isHalt, writesReg, useImm;
    epCorePkg::regIdxT rdAddrA, rdAddrB, dstReg;
    epCorePkg::wordT   imm;
    epCorePkg::aluOpT  aluOp;
    epCorePkg::condT   cond;

    // Sequencer to datapath
    epCorePkg::wordT   instr, opA, opB, wrData;
    logic              loadResult, updateFlags, wrEn;
    epCorePkg::regIdxT wrAddr;

    // Datapath back to sequencer
    epCorePkg::wordT   rdDataA, rdDataB, result;
    epCorePkg::flagsT  flags;

    epSequencer #(
        .ResetVector(ResetVector)
    ) sequencer (
        .iClk(iClk), .rstN(rstN), .memRdData(memRdData),
        .isBranch(isBranch), .isLoad(isLoad), .isStore(isStore),
        .isDirect(isDirect), .isAlu(isAlu), .isHalt(isHalt),
        .writesReg(writesReg), .useImm(useImm), .dstReg(dstReg),
        .imm(imm), .cond(cond), .rdDataA(rdDataA), .rdDataB(rdDataB),
        .result(result), .flags(flags),
        .memAddr(memAddr), .memWrData(memWrData), .memWrite(memWrite),
        .halted(halted), .instr(instr), .opA(opA), .opB(opB),
        .loadResult(loadResult), .updateFlags(updateFlags),
        .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData)
    );

    epDecoder decoder (
        .instr(instr),
        .isBranch(isBranch), .isLoad(isLoad), .isStore(isStore),
        .isDirect(isDirect), .isAlu(isAlu), .isHalt(isHalt),
        .writesReg(writesReg), .useImm(useImm),
        .rdAddrA(rdAddrA), .rdAddrB(rdAddrB), .wrAddr(dstReg),
        .imm(imm), .aluOp(aluOp), .cond(cond)
    );

    epRegFile regFile (
        .iClk(iClk), .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
        .rdAddrA(rdAddrA), .rdAddrB(rdAddrB),
        .rdDataA(rdDataA), .rdDataB(rdDataB)
    );

    epExecUnit execUnit (
        .iClk(iClk), .rstN(rstN), .opA(opA), .opB(opB), .aluOp(aluOp),
        .loadResult(loadResult), .updateFlags(updateFlags),
        .result(result), .flags(flags)
    );

endmodule

`default_nettype wire

// File: hw/epCorePkg.sv
`default_nettype none

package epCorePkg;

    // Widths with a meaning
    typedef logic [31:0] wordT;
    typedef logic [32:0] resultT;
    typedef logic [3:0]  regIdxT;
    typedef logic [4:0]  aluOpT;
    typedef logic [3:0]  condT;
    typedef logic [2:0]  flagsT;
    typedef logic [19:0] immT;

    // Leading-one class prefixes
    localparam logic [2:0] BranchStd = 3'b000;
    localparam logic [1:0] PfxLoad   = 2'b01;
    localparam logic [2:0] PfxDirect = 3'b001;
    localparam logic [3:0] PfxAlu    = 4'b0001;
    localparam logic [5:0] PfxCore   = 6'b000001;

    // Core operation field
    localparam logic [5:0] CoreOpHalt = 6'd2;

    // ALU field codes
    localparam aluOpT AluAdc  = 5'd0;
    localparam aluOpT AluSbc  = 5'd1;
    localparam aluOpT AluAnd  = 5'd2;
    localparam aluOpT AluOr   = 5'd3;
    localparam aluOpT AluXor  = 5'd4;
    localparam aluOpT AluNot  = 5'd5;
    localparam aluOpT AluShl  = 5'd6;
    localparam aluOpT AluAsr  = 5'd7;
    localparam aluOpT AluShr  = 5'd8;
    localparam aluOpT AluAndN = 5'd11;
    localparam aluOpT AluSub  = 5'd14;
    localparam aluOpT AluAnd2 = 5'd15;

    // Internal codes, never taken from the instruction field
    localparam aluOpT AluPassB = 5'd16;
    // Address add, no carry in
    localparam aluOpT AluAddr  = 5'd17;

    // Flag bit positions
    localparam int FlagCarry = 2;
    localparam int FlagZero  = 1;
    localparam int FlagNeg   = 0;

    // Five steps per instruction
    typedef enum logic [2:0] {
        StReset,
        StFetch,
        StDecode,
        StExecute,
        StMemory,
        StWriteback,
        StHalt
    } seqStateT;

endpackage

`default_nettype wire

// File: hw/epDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module epDecoder (
    input  epCorePkg::wordT   instr,
    output logic              isBranch,
    output logic              isLoad,
    output logic              isStore,
    output logic              isDirect,
    output logic              isAlu,
    output logic              isHalt,
    output logic              writesReg,
    output logic              useImm,
    output epCorePkg::regIdxT rdAddrA,
    output epCorePkg::regIdxT rdAddrB,
    output epCorePkg::regIdxT wrAddr,
    output epCorePkg::wordT   imm,
    output epCorePkg::aluOpT  aluOp,
    output epCorePkg::condT   cond
);

    logic             isLoadStore;
    logic             isCore;
    logic             isDirectOr;
    logic             isAluImm;
    epCorePkg::immT   value;

    // Class by leading-one prefix
    assign isBranch    = instr[31] && (instr[30:28] == epCorePkg::BranchStd);
    assign isLoadStore = (instr[31:30] == epCorePkg::PfxLoad);
    assign isLoad      = isLoadStore && !instr[29];
    assign isStore     = isLoadStore && instr[29];
    assign isDirect    = (instr[31:29] == epCorePkg::PfxDirect);
    assign isDirectOr  = isDirect && instr[28];
    assign isAlu       = (instr[31:28] == epCorePkg::PfxAlu);
    assign isAluImm    = isAlu && instr[27];
    assign isCore      = (instr[31:26] == epCorePkg::PfxCore);
    assign isHalt      = isCore && (instr[25:20] == epCorePkg::CoreOpHalt);

    assign writesReg = isLoad || isDirect || isAlu;
    assign useImm    = isBranch || isLoadStore || isDirect || isAluImm;
    assign cond      = instr[27:24];
    assign value     = instr[19:0];

    always_comb begin
        rdAddrA = '0;
        rdAddrB = '0;
        wrAddr  = '0;
        imm     = '0;
        aluOp   = epCorePkg::AluPassB;
        if (isBranch) begin
            rdAddrA = instr[23:20];
            imm     = {{12{value[19]}}, value};
            aluOp   = epCorePkg::AluAddr;
        end else if (isLoadStore) begin
            rdAddrA = instr[27:24];
            // Stores read their data register on port B
            rdAddrB = instr[23:20];
            wrAddr  = instr[23:20];
            imm     = {12'd0, value};
            aluOp   = epCorePkg::AluAddr;
        end else if (isDirect) begin
            rdAddrA = instr[27:24];
            wrAddr  = instr[27:24];
            imm     = epCorePkg::wordT'(value) << instr[23:20];
            aluOp   = isDirectOr ? epCorePkg::AluOr : epCorePkg::AluPassB;
        end else if (isAlu) begin
            rdAddrA = instr[15:12];
            rdAddrB = instr[11:8];
            wrAddr  = instr[19:16];
            // Byte value placed at an even bit position
            imm     = epCorePkg::wordT'(instr[7:0]) << {instr[11:8], 1'b0};
            aluOp   = instr[24:20];
        end
    end

endmodule

`default_nettype wire

// File: hw/epExecUnit.sv
`timescale 1ns/1ps
`default_nettype none

module epExecUnit (
    input  logic             iClk,
    input  logic             rstN,
    input  epCorePkg::wordT  opA,
    input  epCorePkg::wordT  opB,
    input  epCorePkg::aluOpT aluOp,
    input  logic             loadResult,
    input  logic             updateFlags,
    output epCorePkg::wordT  result,
    output epCorePkg::flagsT flags
);

    epCorePkg::resultT aluOut;
    epCorePkg::resultT resultReg;
    epCorePkg::resultT extA;
    epCorePkg::resultT extB;
    logic [4:0]        shAmt;
    logic              carryIn;

    assign extA    = {1'b0, opA};
    assign extB    = {1'b0, opB};
    assign shAmt   = opB[4:0];
    assign carryIn = flags[epCorePkg::FlagCarry];

    always_comb begin
        case (aluOp)
            epCorePkg::AluAdc:   aluOut = extA + extB + carryIn;
            epCorePkg::AluSbc:   aluOut = extA - (extB + carryIn);
            epCorePkg::AluAnd,
            epCorePkg::AluAnd2:  aluOut = extA & extB;
            epCorePkg::AluOr:    aluOut = extA | extB;
            epCorePkg::AluXor:   aluOut = extA ^ extB;
            epCorePkg::AluNot:   aluOut = {1'b0, ~opA};
            // Bit shifted past 31 lands in the carry
            epCorePkg::AluShl:   aluOut = extA << shAmt;
            epCorePkg::AluAsr:   aluOut = {1'b0, epCorePkg::wordT'($signed(opA) >>> shAmt)};
            epCorePkg::AluShr:   aluOut = {1'b0, opA >> shAmt};
            epCorePkg::AluAndN:  aluOut = {1'b0, opA & ~opB};
            epCorePkg::AluSub:   aluOut = extA - extB;
            epCorePkg::AluPassB: aluOut = extB;
            epCorePkg::AluAddr:  aluOut = extA + extB;
            default:             aluOut = '0;
        endcase
    end

    always_ff @(posedge iClk) begin
        if (!rstN) begin
            resultReg <= '0;
        end else if (loadResult) begin
            resultReg <= aluOut;
        end
    end

    always_ff @(posedge iClk) begin
        if (!rstN) begin
            flags <= '0;
        end else if (updateFlags) begin
            flags[epCorePkg::FlagCarry] <= resultReg[32];
            flags[epCorePkg::FlagZero]  <= (resultReg[31:0] == '0);
            flags[epCorePkg::FlagNeg]   <= resultReg[31];
        end
    end

    assign result = resultReg[31:0];

endmodule

`default_nettype wire

// File: hw/epRegFile.sv
`timescale 1ns/1ps
`default_nettype none

module epRegFile (
    input  logic              iClk,
    input  logic              wrEn,
    input  epCorePkg::regIdxT wrAddr,
    input  epCorePkg::wordT   wrData,
    input  epCorePkg::regIdxT rdAddrA,
    input  epCorePkg::regIdxT rdAddrB,
    output epCorePkg::wordT   rdDataA,
    output epCorePkg::wordT   rdDataB
);

    epCorePkg::wordT regs [16];

    // Single write port
    always_ff @(posedge iClk) begin
        if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Asynchronous reads, no bypass needed
    // since reads and writes are in different steps
    assign rdDataA = regs[rdAddrA];
    assign rdDataB = regs[rdAddrB];

endmodule

`default_nettype wire

// File: hw/epSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module epSequencer #(
    parameter epCorePkg::wordT ResetVector = '0
) (
    input  logic              iClk,
    input  logic              rstN,
    input  epCorePkg::wordT   memRdData,
    input  logic              isBranch,
    input  logic              isLoad,
    input  logic              isStore,
    input  logic              isDirect,
    input  logic              isAlu,
    input  logic              isHalt,
    input  logic              writesReg,
    input  logic              useImm,
    input  epCorePkg::regIdxT dstReg,
    input  epCorePkg::wordT   imm,
    input  epCorePkg::condT   cond,
    input  epCorePkg::wordT   rdDataA,
    input  epCorePkg::wordT   rdDataB,
    input  epCorePkg::wordT   result,
    input  epCorePkg::flagsT  flags,
    output epCorePkg::wordT   memAddr,
    output epCorePkg::wordT   memWrData,
    output logic              memWrite,
    output logic              halted,
    output epCorePkg::wordT   instr,
    output epCorePkg::wordT   opA,
    output epCorePkg::wordT   opB,
    output logic              loadResult,
    output logic              updateFlags,
    output logic              wrEn,
    output epCorePkg::regIdxT wrAddr,
    output epCorePkg::wordT   wrData
);

    epCorePkg::seqStateT state;
    epCorePkg::seqStateT nextState;
    epCorePkg::wordT     ip;
    epCorePkg::wordT     loadData;
    logic                condMet;
    logic                branchTaken;

    always_comb begin
        case (state)
            epCorePkg::StReset:     nextState = epCorePkg::StFetch;
            epCorePkg::StFetch:     nextState = epCorePkg::StDecode;
            epCorePkg::StDecode:    nextState = epCorePkg::StExecute;
            epCorePkg::StExecute:   nextState = epCorePkg::StMemory;
            epCorePkg::StMemory:    nextState = epCorePkg::StWriteback;
            epCorePkg::StWriteback: nextState = isHalt ? epCorePkg::StHalt : epCorePkg::StFetch;
            default:                nextState = epCorePkg::StHalt;
        endcase
    end

    always_ff @(posedge iClk) begin
        if (!rstN) begin
            state <= epCorePkg::StReset;
            ip    <= '0;
            instr <= '0;
        end else begin
            state <= nextState;
            if (state == epCorePkg::StReset) begin
                ip <= ResetVector;
            end else if (state == epCorePkg::StWriteback) begin
                ip <= branchTaken ? result : ip + 32'd1;
            end
            if (state == epCorePkg::StFetch) begin
                instr <= memRdData;
            end
        end
    end

    // Operand and data latches
    always_ff @(posedge iClk) begin
        if (state == epCorePkg::StDecode) begin
            opA       <= rdDataA;
            opB       <= useImm ? imm : rdDataB;
            memWrData <= rdDataB;
        end
        if (state == epCorePkg::StMemory && isLoad) begin
            loadData <= memRdData;
        end
    end

    // Conditions 7, 8 and 11 to 15 are never taken
    always_comb begin
        case (cond)
            4'd0:    condMet = 1'b1;
            4'd1:    condMet = flags[epCorePkg::FlagZero];
            4'd2:    condMet = !flags[epCorePkg::FlagZero];
            4'd3:    condMet = flags[epCorePkg::FlagCarry];
            4'd4:    condMet = !flags[epCorePkg::FlagCarry];
            4'd5:    condMet = flags[epCorePkg::FlagNeg];
            4'd6:    condMet = !flags[epCorePkg::FlagNeg];
            4'd9:    condMet = flags[epCorePkg::FlagCarry] && !flags[epCorePkg::FlagZero];
            4'd10:   condMet = !flags[epCorePkg::FlagCarry] || flags[epCorePkg::FlagZero];
            default: condMet = 1'b0;
        endcase
    end

    assign branchTaken = isBranch && condMet;

    assign memAddr  = (state == epCorePkg::StFetch) ? ip : result;
    assign memWrite = (state == epCorePkg::StMemory) && isStore;
    assign halted   = (state == epCorePkg::StHalt);

    assign loadResult  = (state == epCorePkg::StExecute);
    assign updateFlags = (state == epCorePkg::StWriteback) && isAlu;
    assign wrEn        = (state == epCorePkg::StWriteback) && writesReg;
    assign wrAddr      = dstReg;
    assign wrData      = (isAlu || isDirect) ? result : loadData;

endmodule

`default_nettype wire

// File: verif/epCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module epCoreTb;

    localparam epCorePkg::wordT ResetVec = 32'd16;
    localparam int DataBase = 512;
    localparam int DumpBase = 768;
    localparam int NumRand  = 60;
    localparam int MaxSteps = 200;

    logic            iClk;
    logic            rstN;
    epCorePkg::wordT memRdData;
    epCorePkg::wordT memAddr;
    epCorePkg::wordT memWrData;
    logic            memWrite;
    logic            halted;

    epCorePkg::wordT  mem [1024];
    epCorePkg::wordT  image [1024];
    epCorePkg::wordT  modelMem [1024];
    epCorePkg::wordT  refRegs [16];
    epCorePkg::flagsT refFlags;
    epCorePkg::wordT  fetchQ [$];
    epCorePkg::wordT  storeAddrQ [$];
    epCorePkg::wordT  storeDataQ [$];
    int               seed;
    int               errors;
    int               storeErrors;
    int               totalErrors;
    int               checks;
    int               storeIdx;
    int               numSteps;
    int               failCount;
    logic             hung;

    epCore #(
        .ResetVector(ResetVec)
    ) UUT (
        .iClk(iClk),
        .rstN(rstN),
        .memRdData(memRdData),
        .memAddr(memAddr),
        .memWrData(memWrData),
        .memWrite(memWrite),
        .halted(halted)
    );

    initial begin
        iClk = 1'b0;
        forever #4 iClk = ~iClk;
    end

    // Memory answers within the cycle
    assign memRdData = mem[memAddr[9:0]];

    always @(posedge iClk) begin
        if (memWrite) begin
            mem[memAddr[9:0]] <= memWrData;
        end
    end

    task automatic checkWord(input string name, input epCorePkg::wordT actual,
                             input epCorePkg::wordT expected, inout int errCount);
        checks++;
        assert (actual === expected) else begin
            $display("ERROR at %0t: %s = %h, expected %h", $time, name, actual, expected);
            errCount++;
        end
    endtask

    // Stores compared in program order
    always @(negedge iClk) begin
        if (rstN && memWrite) begin
            if (storeIdx < storeAddrQ.size()) begin
                checkWord("memAddr", memAddr, storeAddrQ[storeIdx], storeErrors);
                checkWord("memWrData", memWrData, storeDataQ[storeIdx], storeErrors);
            end
            storeIdx++;
        end
    end

    function automatic int randBelow(input int n);
        return int'({$random(seed)} % n);
    endfunction

    function automatic logic condTaken(input logic [3:0] c);
        logic cy;
        logic z;
        logic n;
        cy = refFlags[epCorePkg::FlagCarry];
        z  = refFlags[epCorePkg::FlagZero];
        n  = refFlags[epCorePkg::FlagNeg];
        case (c)
            4'd0:    return 1'b1;
            4'd1:    return z;
            4'd2:    return !z;
            4'd3:    return cy;
            4'd4:    return !cy;
            4'd5:    return n;
            4'd6:    return !n;
            4'd9:    return cy && !z;
            4'd10:   return !cy || z;
            default: return 1'b0;
        endcase
    endfunction

    function automatic epCorePkg::resultT aluRef(input logic [4:0] op,
                                                 input epCorePkg::wordT a,
                                                 input epCorePkg::wordT b);
        logic signed [31:0] sa;
        logic [32:0]        ea;
        logic [32:0]        eb;
        logic [32:0]        cin;
        sa  = a;
        ea  = {1'b0, a};
        eb  = {1'b0, b};
        cin = {32'd0, refFlags[epCorePkg::FlagCarry]};
        case (op)
            5'd0:        return ea + eb + cin;
            5'd1:        return ea - eb - cin;
            5'd2, 5'd15: return {1'b0, a & b};
            5'd3:        return {1'b0, a | b};
            5'd4:        return {1'b0, a ^ b};
            5'd5:        return {1'b0, ~a};
            5'd6:        return ea << b[4:0];
            5'd7:        return {1'b0, 32'(sa >>> b[4:0])};
            5'd8:        return {1'b0, a >> b[4:0]};
            5'd11:       return {1'b0, a & ~b};
            5'd14:       return ea - eb;
            default:     return '0;
        endcase
    endfunction

    task automatic buildProgram();
        int              aluOps [12] = '{0, 1, 2, 3, 4, 5, 6, 7, 8, 11, 14, 15};
        int              pc;
        int              k;
        int              kind;
        int              target;
        int              epiStart;
        logic [3:0]      rd;
        logic [3:0]      rs;
        logic [3:0]      shift;
        epCorePkg::immT  value;
        epCorePkg::wordT word;
        epiStart = ResetVec + 16 + NumRand;
        for (k = 0; k < 1024; k++) begin
            image[k] = {k[15:0] ^ 16'ha5c3, ~k[15:0]};
        end
        for (k = 0; k < 64; k++) begin
            image[DataBase + k] = $random(seed);
        end
        pc = ResetVec;
        // r0 stays zero and serves as base for loads, stores and branches
        for (k = 0; k < 16; k++) begin
            shift = (k == 0) ? 4'd0 : 4'(randBelow(13));
            value = (k == 0) ? 20'd0 : 20'($random(seed));
            image[pc] = {3'b001, 1'b0, k[3:0], shift, value};
            pc++;
        end
        for (k = 0; k < NumRand; k++) begin
            rd   = 4'(1 + randBelow(15));
            rs   = 4'(randBelow(16));
            word = $random(seed);
            kind = randBelow(7);
            case (kind)
                0, 1, 2: image[pc] = {4'b0001, kind == 2, 2'b00, 5'(aluOps[randBelow(12)]),
                                      rd, rs, word[11:0]};
                3:       image[pc] = {3'b001, word[31], rd, 4'(randBelow(13)), word[19:0]};
                4:       image[pc] = {4'b0100, 4'd0, rd, 20'(DataBase + randBelow(64))};
                5:       image[pc] = {4'b0110, 4'd0, rs, 20'(DataBase + randBelow(64))};
                default: begin
                    // Forward only, never past the epilogue
                    target = pc + 1 + randBelow(4);
                    if (target > epiStart) begin
                        target = epiStart;
                    end
                    image[pc] = {4'b1000, word[15:12], 4'd0, 20'(target)};
                end
            endcase
            pc++;
        end
        for (k = 0; k < 16; k++) begin
            image[pc] = {4'b0110, 4'd0, k[3:0], 20'(DumpBase + k)};
            pc++;
        end
        image[pc] = {6'b000001, 6'd2, 20'd0};
    endtask

    task automatic runModel();
        epCorePkg::wordT   ip;
        epCorePkg::wordT   nextIp;
        epCorePkg::wordT   ins;
        epCorePkg::wordT   addr;
        epCorePkg::wordT   opB;
        epCorePkg::resultT res;
        logic              done;
        modelMem = image;
        ip       = ResetVec;
        refFlags = '0;
        done     = 1'b0;
        numSteps = 0;
        while (!done && numSteps < MaxSteps) begin
            ins    = modelMem[ip[9:0]];
            nextIp = ip + 32'd1;
            fetchQ.push_back(ip);
            numSteps++;
            if (ins[31]) begin
                if (condTaken(ins[27:24])) begin
                    nextIp = refRegs[ins[23:20]] + {{12{ins[19]}}, ins[19:0]};
                end
            end else if (ins[31:30] == 2'b01) begin
                addr = refRegs[ins[27:24]] + {12'd0, ins[19:0]};
                if (ins[29]) begin
                    modelMem[addr[9:0]] = refRegs[ins[23:20]];
                    storeAddrQ.push_back(addr);
                    storeDataQ.push_back(refRegs[ins[23:20]]);
                end else begin
                    refRegs[ins[23:20]] = modelMem[addr[9:0]];
                end
            end else if (ins[31:29] == 3'b001) begin
                opB = {12'd0, ins[19:0]} << ins[23:20];
                refRegs[ins[27:24]] = ins[28] ? (refRegs[ins[27:24]] | opB) : opB;
            end else if (ins[31:28] == 4'b0001) begin
                opB = ins[27] ? ({24'd0, ins[7:0]} << (2 * ins[11:8])) : refRegs[ins[11:8]];
                res = aluRef(ins[24:20], refRegs[ins[15:12]], opB);
                refRegs[ins[19:16]] = res[31:0];
                refFlags[epCorePkg::FlagCarry] = res[32];
                refFlags[epCorePkg::FlagZero]  = (res[31:0] == 32'd0);
                refFlags[epCorePkg::FlagNeg]   = res[31];
            end else begin
                // Halt is the only other word the generator emits
                done = 1'b1;
            end
            ip = nextIp;
        end
    endtask

    task automatic resetCore();
        int k;
        @(posedge iClk);
        #1 rstN = 1'b0;
        for (k = 0; k < 1024; k++) begin
            mem[k] = image[k];
        end
        // Sixteen rising edges with rstN low
        for (k = 0; k < 15; k++) begin
            @(posedge iClk);
            @(negedge iClk);
            checks++;
            assert (!memWrite && !halted) else begin
                $display("memWrite or halted was high during reset at %0t", $time);
                errors++;
            end
        end
        @(posedge iClk);
        #1 rstN = 1'b1;
    endtask

    task automatic runProgram();
        int cyc;
        int idx;
        int limit;
        limit = numSteps * 5 + 20;
        idx   = 0;
        hung  = 1'b0;
        // First negedge still falls in the StReset cycle
        cyc = -1;
        while (!halted && cyc < limit) begin
            @(negedge iClk);
            if (cyc >= 0 && cyc % 5 == 0 && idx < numSteps) begin
                checkWord("memAddr", memAddr, fetchQ[idx], errors);
                idx++;
            end
            cyc++;
        end
        checks++;
        assert (halted && idx == numSteps) else begin
            $display("core did not halt after %0d instructions within %0d cycles",
                     numSteps, limit);
            errors++;
            hung = 1'b1;
        end
    endtask

    task automatic watchHalt();
        epCorePkg::wordT held;
        int              k;
        held = memAddr;
        for (k = 0; k < 50; k++) begin
            @(negedge iClk);
            checks++;
            assert (halted && !memWrite && memAddr === held) else begin
                $display("core left halt or accessed memory at %0t", $time);
                errors++;
            end
        end
    endtask

    task automatic reportTest(input string name, input int failures);
        $display("Test %s: %s", name, (failures == 0) ? "passed" : "failed");
    endtask

    initial begin
        rstN        = 1'b0;
        seed        = 32'hcca0;
        errors      = 0;
        storeErrors = 0;
        checks      = 0;
        storeIdx    = 0;
        buildProgram();
        runModel();
        failCount = errors;
        resetCore();
        reportTest("reset", errors - failCount);
        failCount = errors;
        runProgram();
        reportTest("fetch trace", errors - failCount);
        if (!hung) begin
            failCount = errors;
            watchHalt();
            reportTest("halt", errors - failCount);
            checkWord("store count", 32'(storeIdx), 32'(storeAddrQ.size()), storeErrors);
            reportTest("stores", storeErrors);
            failCount = errors;
            for (int r = 0; r < 16; r++) begin
                checkWord($sformatf("mem[%0d]", DumpBase + r), mem[DumpBase + r],
                          refRegs[r], errors);
            end
            reportTest("register dump", errors - failCount);
            // Replay from the reset vector after halt
            failCount = errors + storeErrors;
            storeIdx  = 0;
            resetCore();
            runProgram();
            checkWord("store count", 32'(storeIdx), 32'(storeAddrQ.size()), storeErrors);
            reportTest("reset replay", errors + storeErrors - failCount);
        end
        totalErrors = errors + storeErrors + UUT.chk.violations;
        $display("Checks: %0d, errors: %0d", checks, totalErrors);
        if (totalErrors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/epCore_chk.sv
`timescale 1ns/1ps
`default_nettype none

module epCoreChk (
    input logic iClk,
    input logic rstN,
    input logic memWrite,
    input logic halted
);

    int violations = 0;

    // Write strobe covers the memory cycle only
    singleWrite: assert property (@(posedge iClk) disable iff (!rstN)
        memWrite |=> !memWrite)
        else begin
            $error("memWrite high on two consecutive cycles");
            violations++;
        end

    noWriteHalted: assert property (@(posedge iClk) disable iff (!rstN)
        !(memWrite && halted))
        else begin
            $error("memWrite high while halted");
            violations++;
        end

    // Only reset leaves halt
    haltSticky: assert property (@(posedge iClk) disable iff (!rstN)
        halted |=> halted)
        else begin
            $error("halted fell without reset");
            violations++;
        end

endmodule

bind epCore epCoreChk chk (
    .iClk(iClk),
    .rstN(rstN),
    .memWrite(memWrite),
    .halted(halted)
);

`default_nettype wire
